// File: hw/dma_pkg.sv
// ******************************
// word addresses are 21 bits, data words 16 bits
// strobe and control bit positions follow the Z80 register map
// ******************************

package dma_pkg;

    typedef logic [20:0] addr_t;   // DRAM word address
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;   // Z80 bus and SPI byte
    typedef logic [2:0]  dev_t;

    // target device codes
    localparam dev_t DEV_RAM   = 3'd1;
    localparam dev_t DEV_SPI   = 3'd2;
    localparam dev_t DEV_IDE   = 3'd3;
    localparam dev_t DEV_CRAM  = 3'd4;  // write-only
    localparam dev_t DEV_SFILE = 3'd5;  // write-only

    // bit index of each register strobe in the port-write vector
    localparam int unsigned REG_SADDR_L = 0;
    localparam int unsigned REG_SADDR_H = 1;
    localparam int unsigned REG_SADDR_X = 2;
    localparam int unsigned REG_DADDR_L = 3;
    localparam int unsigned REG_DADDR_H = 4;
    localparam int unsigned REG_DADDR_X = 5;
    localparam int unsigned REG_LEN     = 6;
    localparam int unsigned REG_LAUNCH  = 7;
    localparam int unsigned REG_NUM     = 8;
    localparam int unsigned NUM_REGS    = 9;

    // control byte layout, device code sits in bits 2..0
    localparam int unsigned CTL_WNR   = 7;  // 1 = RAM to device
    localparam int unsigned CTL_ZWT   = 6;
    localparam int unsigned CTL_SALGN = 5;
    localparam int unsigned CTL_DALGN = 4;
    localparam int unsigned CTL_ASZ   = 3;  // aligned line size, 0 = 128, 1 = 256 words

endpackage

// File: hw/dma_cfg_if.sv
// ******************************
// values are held from launch until the next launch
// launch is a single-cycle strobe
// ******************************

interface dma_cfg_if;
    import dma_pkg::*;

    dev_t  device;
    logic  wnr;        // 0 = device to RAM
    logic  zwt;
    logic  salgn;
    logic  dalgn;
    logic  asz;
    byte_t burst_len;  // words per burst minus one
    byte_t burst_num;  // bursts minus one
    logic  launch;

    modport regs (
        output device,
        output wnr,
        output zwt,
        output salgn,
        output dalgn,
        output asz,
        output burst_len,
        output burst_num,
        output launch
    );

    // alignment bits go to the address generators straight from the top
    modport engine (
        input device,
        input wnr,
        input zwt,
        input burst_len,
        input burst_num,
        input launch
    );

endinterface

// File: hw/dma_regs.sv
// ******************************
// all register writes are dropped while a transfer runs
// latched fields are not reset, program before launch
// ******************************

module dma_regs (
    input  logic                            clk,
    input  logic [dma_pkg::NUM_REGS-1:0]    port_wr,
    input  dma_pkg::byte_t                  zdata,
    input  logic                            active,
    dma_cfg_if.regs                         cfg,
    output logic                            src_ld_lo,
    output logic                            src_ld_hi,
    output logic                            src_ld_ext,
    output logic                            dst_ld_lo,
    output logic                            dst_ld_hi,
    output logic                            dst_ld_ext
);
    import dma_pkg::*;

    logic [NUM_REGS-1:0] wr;

    assign wr = port_wr & {NUM_REGS{~active}};  // masked while busy

    // byte loads into the address counters
    assign src_ld_lo  = wr[REG_SADDR_L];
    assign src_ld_hi  = wr[REG_SADDR_H];
    assign src_ld_ext = wr[REG_SADDR_X];
    assign dst_ld_lo  = wr[REG_DADDR_L];
    assign dst_ld_hi  = wr[REG_DADDR_H];
    assign dst_ld_ext = wr[REG_DADDR_X];

    // the engine loads its counters on this same edge
    assign cfg.launch = wr[REG_LAUNCH];

    always_ff @(posedge clk)
    begin
        if (wr[REG_LEN])
        begin
            cfg.burst_len <= zdata;
        end
        if (wr[REG_NUM])
        begin
            cfg.burst_num <= zdata;
        end
    end

    // control byte, written together with the launch
    always_ff @(posedge clk)
    begin
        if (wr[REG_LAUNCH])
        begin
            cfg.wnr    <= zdata[CTL_WNR];
            cfg.zwt    <= zdata[CTL_ZWT];
            cfg.salgn  <= zdata[CTL_SALGN];
            cfg.dalgn  <= zdata[CTL_DALGN];
            cfg.asz    <= zdata[CTL_ASZ];
            cfg.device <= zdata[2:0];
        end
    end

    // a launch only comes from idle and always starts a transfer
    a_launch_from_idle: assert property (
        @(posedge clk) cfg.launch |-> !active ##1 active
    );

endmodule

// File: hw/dma_addr_gen.sv
// ******************************
// a step takes priority over a Z80 byte load
// aligned mode reloads the low part at each burst end
// ******************************

module dma_addr_gen (
    input  logic            clk,
    input  dma_pkg::byte_t  zdata,
    input  logic            ld_lo,
    input  logic            ld_hi,
    input  logic            ld_ext,
    input  logic            align,
    input  logic            asz,
    input  logic            step,
    input  logic            burst_end,
    output dma_pkg::addr_t  addr
);
    import dma_pkg::*;

    byte_t       saved_lo;  // low part restored at each burst end
    logic [8:0]  inc_lo;
    byte_t       next_lo;
    logic [1:0]  add_line;
    logic [13:0] next_line;
    logic        next_mid;
    addr_t       next_addr;

    assign inc_lo  = {1'b0, addr[7:0]} + 9'd1;
    assign next_lo = (align && burst_end) ? saved_lo : inc_lo[7:0];

    // aligned: +128 or +256 words per burst; unaligned: carry out of the low byte
    always_comb
    begin
        if (align)
        begin
            add_line = {burst_end && asz, burst_end && !asz};
        end
        else
        begin
            add_line = {inc_lo[8], 1'b0};
        end
    end

    assign next_line = addr[20:7] + {12'd0, add_line};

    // bit 7 belongs to the low part only for 256-word lines
    assign next_mid  = align ? (asz ? next_lo[7] : next_line[0]) : inc_lo[7];
    assign next_addr = {next_line[13:1], next_mid, next_lo[6:0]};

    always_ff @(posedge clk)
    begin
        if (step)
        begin
            addr <= next_addr;
        end
        else
        begin
            if (ld_lo)
            begin
                addr[6:0]     <= zdata[7:1];
                saved_lo[6:0] <= zdata[7:1];
            end
            if (ld_hi)
            begin
                addr[12:7]  <= zdata[5:0];
                saved_lo[7] <= zdata[0];
            end
            if (ld_ext)
            begin
                addr[20:13] <= zdata;
            end
        end
    end

endmodule

// File: hw/dma_engine.sv
// ******************************
// each word is a read phase then a write phase
// peers hold off completion as long as they like
// ******************************

module dma_engine (
    input  logic            clk,
    input  logic            rst_n,
    dma_cfg_if.engine       cfg,
    input  dma_pkg::addr_t  src_addr,
    input  dma_pkg::addr_t  dst_addr,
    output logic            src_step,
    output logic            dst_step,
    output logic            burst_end,
    output logic            active,
    output logic            wait_z80,
    output dma_pkg::word_t  data,
    output dma_pkg::byte_t  wraddr,
    output dma_pkg::addr_t  dram_addr,
    input  dma_pkg::word_t  dram_rddata,
    output dma_pkg::word_t  dram_wrdata,
    output logic            dram_req,
    output logic            dram_rnw,
    input  logic            dram_next,
    input  dma_pkg::byte_t  spi_rddata,
    output dma_pkg::byte_t  spi_wrdata,
    output logic            spi_req,
    input  logic            spi_stb,
    input  logic            spi_start,
    input  dma_pkg::word_t  ide_in,
    output dma_pkg::word_t  ide_out,
    output logic            ide_req,
    output logic            ide_rnw,
    input  logic            ide_stb,
    output logic            cram_we,
    output logic            sfile_we
);
    import dma_pkg::*;

    logic       phase;      // 0 = read, 1 = write
    logic       bsel;       // SPI byte lane, 0 = low
    logic       dv_ram, dv_spi, dv_ide, dv_crm, dv_sfl;
    logic       state_rd, state_wr, state_mem, state_dev;
    logic       dev_req, dev_stb, phase_end, word_done;
    logic       spi_int_stb, spi_int_start, ide_int_stb;
    byte_t      b_ctr;      // words left in burst
    logic [8:0] b_ctr_dec;
    logic [8:0] n_ctr;      // bursts left, msb set when idle
    logic [8:0] n_ctr_dec;

    assign dv_ram = (cfg.device == DEV_RAM);
    assign dv_spi = (cfg.device == DEV_SPI);
    assign dv_ide = (cfg.device == DEV_IDE);
    assign dv_crm = (cfg.device == DEV_CRAM) && cfg.wnr;   // tables are write-only
    assign dv_sfl = (cfg.device == DEV_SFILE) && cfg.wnr;

    // RAM mode uses DRAM in both phases
    assign state_rd  = ~phase;
    assign state_wr  = phase;
    assign state_mem = dv_ram || (cfg.wnr ^ phase);
    assign state_dev = !dv_ram && (cfg.wnr ^ !phase);

    assign spi_int_stb   = dv_spi && spi_stb;
    assign spi_int_start = dv_spi && spi_start;
    assign ide_int_stb   = dv_ide && ide_stb;

    assign dev_req  = active && state_dev;
    assign cram_we  = dev_req && dv_crm && state_wr;
    assign sfile_we = dev_req && dv_sfl && state_wr;
    assign dev_stb  = cram_we || sfile_we || ide_int_stb || (spi_int_stb && bsel);

    assign phase_end = active && ((state_mem && dram_next) || (state_dev && dev_stb));
    assign word_done = phase_end && state_wr;
    assign src_step  = phase_end && state_rd;
    assign dst_step  = word_done;

    // DRAM side
    assign dram_req    = active && state_mem;
    assign dram_rnw    = state_rd;
    assign dram_addr   = state_rd ? src_addr : dst_addr;
    assign dram_wrdata = data;

    assign spi_req    = dev_req && dv_spi;
    assign spi_wrdata = {8{state_rd}} | (bsel ? data[15:8] : data[7:0]);  // idle FF on reads
    assign ide_req    = dev_req && dv_ide;
    assign ide_rnw    = state_rd;
    assign ide_out    = data;

    assign wraddr   = dst_addr[7:0];
    assign wait_z80 = cfg.zwt && active;

    // read data capture
    always_ff @(posedge clk)
    begin
        if (state_rd)
        begin
            if (state_mem && dram_next)
            begin
                data <= dram_rddata;
            end
            if (ide_int_stb)
            begin
                data <= ide_in;
            end
            if (spi_int_start)
            begin
                if (bsel)
                begin
                    data[15:8] <= spi_rddata;
                end
                else
                begin
                    data[7:0] <= spi_rddata;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            phase <= 1'b0;
            bsel  <= 1'b0;
        end
        else if (cfg.launch)
        begin
            phase <= 1'b0;
            bsel  <= 1'b0;
        end
        else
        begin
            if (phase_end)
            begin
                phase <= ~phase;
            end
            if (spi_int_stb)
            begin
                bsel <= ~bsel;  // two bytes per word
            end
        end
    end

    assign b_ctr_dec = {1'b0, b_ctr} - 9'd1;
    assign burst_end = b_ctr_dec[8];    // last word of the burst
    assign n_ctr_dec = n_ctr - {8'd0, burst_end};
    assign active    = ~n_ctr[8];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            n_ctr <= 9'h100;
        end
        else if (cfg.launch)
        begin
            n_ctr <= {1'b0, cfg.burst_num};
        end
        else if (word_done)
        begin
            n_ctr <= n_ctr_dec;     // wraps to idle after the last burst
        end
    end

    always_ff @(posedge clk)
    begin
        if (cfg.launch)
        begin
            b_ctr <= cfg.burst_len;
        end
        else if (word_done)
        begin
            b_ctr <= burst_end ? cfg.burst_len : b_ctr_dec[7:0];
        end
    end

    a_one_peer: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dram_req && (spi_req || ide_req || cram_we || sfile_we)) |-> dv_ram
    );

    a_quiet_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !active |-> !(dram_req || spi_req || ide_req || cram_we || sfile_we)
    );

endmodule

// File: hw/dma_top.sv
// ******************************
// DRAM, SPI, IDE and table ports
// connect to external controllers
// ******************************

module dma_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [dma_pkg::NUM_REGS-1:0]    port_wr,
    input  dma_pkg::byte_t                  zdata,
    output logic                            dma_act,
    output logic                            wait_z80,
    output dma_pkg::word_t                  data,
    output dma_pkg::byte_t                  wraddr,
    output dma_pkg::addr_t                  dram_addr,
    input  dma_pkg::word_t                  dram_rddata,
    output dma_pkg::word_t                  dram_wrdata,
    output logic                            dram_req,
    output logic                            dram_rnw,
    input  logic                            dram_next,
    input  dma_pkg::byte_t                  spi_rddata,
    output dma_pkg::byte_t                  spi_wrdata,
    output logic                            spi_req,
    input  logic                            spi_stb,
    input  logic                            spi_start,
    input  dma_pkg::word_t                  ide_in,
    output dma_pkg::word_t                  ide_out,
    output logic                            ide_req,
    output logic                            ide_rnw,
    input  logic                            ide_stb,
    output logic                            cram_we,
    output logic                            sfile_we
);
    import dma_pkg::*;

    addr_t src_addr, dst_addr;
    logic  src_ld_lo, src_ld_hi, src_ld_ext;
    logic  dst_ld_lo, dst_ld_hi, dst_ld_ext;
    logic  src_step, dst_step, burst_end;

    dma_cfg_if cfg_if ();

    dma_regs i_regs (
        .clk        (clk),
        .port_wr    (port_wr),
        .zdata      (zdata),
        .active     (dma_act),
        .cfg        (cfg_if.regs),
        .src_ld_lo  (src_ld_lo),
        .src_ld_hi  (src_ld_hi),
        .src_ld_ext (src_ld_ext),
        .dst_ld_lo  (dst_ld_lo),
        .dst_ld_hi  (dst_ld_hi),
        .dst_ld_ext (dst_ld_ext)
    );

    dma_addr_gen i_src (
        .clk       (clk),
        .zdata     (zdata),
        .ld_lo     (src_ld_lo),
        .ld_hi     (src_ld_hi),
        .ld_ext    (src_ld_ext),
        .align     (cfg_if.salgn),
        .asz       (cfg_if.asz),
        .step      (src_step),
        .burst_end (burst_end),
        .addr      (src_addr)
    );

    dma_addr_gen i_dst (
        .clk       (clk),
        .zdata     (zdata),
        .ld_lo     (dst_ld_lo),
        .ld_hi     (dst_ld_hi),
        .ld_ext    (dst_ld_ext),
        .align     (cfg_if.dalgn),
        .asz       (cfg_if.asz),
        .step      (dst_step),
        .burst_end (burst_end),
        .addr      (dst_addr)
    );

    dma_engine i_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg_if.engine),
        .src_addr    (src_addr),
        .dst_addr    (dst_addr),
        .src_step    (src_step),
        .dst_step    (dst_step),
        .burst_end   (burst_end),
        .active      (dma_act),
        .wait_z80    (wait_z80),
        .data        (data),
        .wraddr      (wraddr),
        .dram_addr   (dram_addr),
        .dram_rddata (dram_rddata),
        .dram_wrdata (dram_wrdata),
        .dram_req    (dram_req),
        .dram_rnw    (dram_rnw),
        .dram_next   (dram_next),
        .spi_rddata  (spi_rddata),
        .spi_wrdata  (spi_wrdata),
        .spi_req     (spi_req),
        .spi_stb     (spi_stb),
        .spi_start   (spi_start),
        .ide_in      (ide_in),
        .ide_out     (ide_out),
        .ide_req     (ide_req),
        .ide_rnw     (ide_rnw),
        .ide_stb     (ide_stb),
        .cram_we     (cram_we),
        .sfile_we    (sfile_we)
    );

endmodule

// File: tests/tb_dma_devices.sv
// ******************************
// peers answer 0 to 3 random cycles after a request
// DRAM spans all 21 address bits, unwritten words hold a fill pattern
// ******************************

module tb_dma_devices (
    input  logic           clk,
    input  dma_pkg::addr_t dram_addr,
    input  dma_pkg::word_t dram_wrdata,
    input  logic           dram_req,
    input  logic           dram_rnw,
    output dma_pkg::word_t dram_rddata,
    output logic           dram_next,
    input  dma_pkg::byte_t spi_wrdata,
    input  logic           spi_req,
    output dma_pkg::byte_t spi_rddata,
    output logic           spi_stb,
    output logic           spi_start,
    input  dma_pkg::word_t ide_out,
    input  logic           ide_req,
    input  logic           ide_rnw,
    output dma_pkg::word_t ide_in,
    output logic           ide_stb,
    input  logic           cram_we,
    input  logic           sfile_we,
    input  dma_pkg::byte_t wraddr,
    input  dma_pkg::word_t data
);
    timeunit 1ns;
    timeprecision 1ps;
    import dma_pkg::*;

    word_t       mem [0:(1 << 21) - 1];
    logic [36:0] dram_wr_q[$];  // {addr, data}
    addr_t       dram_rd_q[$];
    logic [16:0] ide_q[$];      // {rnw, ide_out}
    byte_t       spi_q[$];      // byte sent on each exchange
    logic [24:0] tbl_q[$];      // {sfile, wraddr, data}

    function automatic word_t fill_word(input addr_t a);
        return a[15:0] ^ {a[20:16], a[20:16], a[20:15]};
    endfunction

    function automatic word_t ide_word(input int unsigned n);
        return 16'hc35a ^ n[15:0];
    endfunction

    function automatic byte_t spi_byte(input int unsigned n);
        return 8'ha5 ^ n[7:0];
    endfunction

    // DRAM, one access per dram_next pulse
    initial
    begin
        int unsigned wait_cnt;
        dram_next   = 1'b0;
        dram_rddata = '0;
        wait_cnt    = 0;
        for (int unsigned a = 0; a < (1 << 21); a++)
        begin
            mem[a] = fill_word(addr_t'(a));
        end
        forever
        begin
            @(negedge clk);
            dram_next = 1'b0;
            if (dram_req === 1'b1)
            begin
                if (wait_cnt == 0)
                begin
                    if (dram_rnw)
                    begin
                        dram_rd_q.push_back(dram_addr);
                        dram_rddata = mem[dram_addr];
                    end
                    else
                    begin
                        mem[dram_addr] = dram_wrdata;
                        dram_wr_q.push_back({dram_addr, dram_wrdata});
                    end
                    dram_next = 1'b1;
                    wait_cnt  = $urandom_range(3, 0);
                end
                else
                begin
                    wait_cnt--;
                end
            end
        end
    end

    // SPI shifts one byte each way per exchange
    initial
    begin
        int unsigned wait_cnt;
        int unsigned cnt;
        spi_stb    = 1'b0;
        spi_start  = 1'b0;
        spi_rddata = '0;
        wait_cnt   = 0;
        cnt        = 0;
        forever
        begin
            @(negedge clk);
            spi_stb   = 1'b0;
            spi_start = 1'b0;
            if (spi_req === 1'b1)
            begin
                if (wait_cnt == 0)
                begin
                    spi_q.push_back(spi_wrdata);
                    spi_rddata = spi_byte(cnt);
                    cnt++;
                    spi_start = 1'b1;
                    spi_stb   = 1'b1;
                    wait_cnt  = $urandom_range(3, 0);
                end
                else
                begin
                    wait_cnt--;
                end
            end
        end
    end

    initial
    begin
        int unsigned wait_cnt;
        int unsigned cnt;
        ide_stb  = 1'b0;
        ide_in   = '0;
        wait_cnt = 0;
        cnt      = 0;
        forever
        begin
            @(negedge clk);
            ide_stb = 1'b0;
            if (ide_req === 1'b1)
            begin
                if (wait_cnt == 0)
                begin
                    ide_q.push_back({ide_rnw, ide_out});
                    ide_in = ide_word(cnt);     // counter word, both directions
                    cnt++;
                    ide_stb  = 1'b1;
                    wait_cnt = $urandom_range(3, 0);
                end
                else
                begin
                    wait_cnt--;
                end
            end
        end
    end

    // table strobes last one cycle
    initial
    begin
        forever
        begin
            @(negedge clk);
            if ((cram_we === 1'b1) || (sfile_we === 1'b1))
            begin
                tbl_q.push_back({sfile_we, wraddr, data});
            end
        end
    end

endmodule

// File: tests/tb_dma.sv
// ******************************
// random transfers to every target, checked against a reference model
// source and destination live in disjoint halves of DRAM
// ******************************

module tb_dma;
    timeunit 1ns;
    timeprecision 1ps;
    import dma_pkg::*;

    localparam int unsigned N_TESTS   = 14;
    localparam int unsigned MAX_WORDS = 16 * 8;    // len up to 15, num up to 7
    localparam int unsigned LIMIT     = N_TESTS * (MAX_WORDS * 2 * 6 + 60) + 100;

    logic                clk;
    logic                rst_n;
    logic [NUM_REGS-1:0] port_wr;
    byte_t               zdata;
    logic                dma_act, wait_z80;
    word_t               data;
    byte_t               wraddr;
    addr_t               dram_addr;
    word_t               dram_rddata, dram_wrdata;
    logic                dram_req, dram_rnw, dram_next;
    byte_t               spi_rddata, spi_wrdata;
    logic                spi_req, spi_stb, spi_start;
    word_t               ide_in, ide_out;
    logic                ide_req, ide_rnw, ide_stb;
    logic                cram_we, sfile_we;
    int unsigned         cycles = 0;
    int unsigned         ide_seen = 0;    // IDE words served so far
    int unsigned         spi_seen = 0;    // SPI bytes exchanged so far

    dma_top i_dma_top (.*);

    tb_dma_devices i_devices (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > LIMIT)
        begin
            $display("timeout: transfers not finished within %0d cycles", LIMIT);
            $display("=== FAIL ===");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first error");
        end
    endtask

    function automatic word_t ide_word(input int unsigned n);
        return 16'hc35a ^ n[15:0];
    endfunction

    function automatic byte_t spi_byte(input int unsigned n);
        return 8'ha5 ^ n[7:0];
    endfunction

    // aligned lines are 128 or 256 words, low part reloads at burst end
    function automatic addr_t next_addr(input addr_t a, input addr_t start, input logic align,
                                        input logic asz, input logic last);
        addr_t line;
        line = asz ? 21'd256 : 21'd128;
        if (!align)
        begin
            return a + 21'd1;
        end
        if (last)
        begin
            return ((a & ~(line - 21'd1)) + line) | (start & (line - 21'd1));
        end
        return (a & ~(line - 21'd1)) | ((a + 21'd1) & (line - 21'd1));
    endfunction

    task automatic write_reg(input int unsigned idx, input byte_t val);
        @(negedge clk);
        port_wr      = '0;
        port_wr[idx] = 1'b1;
        zdata        = val;
        @(negedge clk);
        port_wr = '0;
    endtask

    task automatic load_addr(input logic dst, input addr_t a);
        int unsigned base;
        base = dst ? REG_DADDR_L : REG_SADDR_L;
        write_reg(base, {a[6:0], 1'b0});
        write_reg(base + 1, {2'b00, a[12:7]});  // bit 0 is also saved bit 7
        write_reg(base + 2, a[20:13]);
    endtask

    task automatic run(input dev_t dev, input logic wnr, input logic salgn, input logic dalgn,
                       input logic asz, input logic poke);
        addr_t       src, dst, s, d;
        byte_t       len, num;
        int unsigned words, k;
        logic        from_ram, to_ram, last, zwt;
        word_t       exp_w[$];
        addr_t       src_seq[$];
        addr_t       dst_seq[$];

        src      = {2'b00, 19'($urandom)};
        dst      = {2'b10, 19'($urandom)};
        len      = poke ? 8'd7 : 8'($urandom_range(15, 0));
        num      = poke ? 8'd3 : 8'($urandom_range(7, 0));
        words    = (len + 1) * (num + 1);
        from_ram = (dev == DEV_RAM) || wnr;
        to_ram   = (dev == DEV_RAM) || !wnr;
        zwt      = !wnr;    // Z80 wait bit, both values over the run
        i_devices.dram_wr_q.delete();
        i_devices.dram_rd_q.delete();
        i_devices.ide_q.delete();
        i_devices.spi_q.delete();
        i_devices.tbl_q.delete();

        load_addr(1'b0, src);
        load_addr(1'b1, dst);
        write_reg(REG_LEN, len);
        write_reg(REG_NUM, num);
        write_reg(REG_LAUNCH, {wnr, zwt, salgn, dalgn, asz, dev});
        check("dma_act", dma_act, 1);
        if (poke)
        begin
            // blocked writes, the copy must finish as launched
            write_reg(REG_LEN, 8'h00);
            write_reg(REG_NUM, 8'h00);
            write_reg(REG_DADDR_X, 8'hff);
            check("dma_act", dma_act, 1);
        end
        while (dma_act)
        begin
            if (dram_req && dram_rnw)
            begin
                check("spi_wrdata", spi_wrdata, 8'hff);
            end
            check("wait_z80", wait_z80, zwt);   // held level while busy
            @(negedge clk);
        end

        s = src;
        d = dst;
        for (k = 0; k < words; k++)
        begin
            last = ((k % (len + 1)) == len);
            src_seq.push_back(s);
            dst_seq.push_back(d);
            s = next_addr(s, src, salgn, asz, last);
            d = next_addr(d, dst, dalgn, asz, last);
            if (from_ram)
            begin
                exp_w.push_back(i_devices.mem[src_seq[k]]);
            end
            else if (dev == DEV_IDE)
            begin
                exp_w.push_back(ide_word(ide_seen + k));
            end
            else
            begin
                exp_w.push_back({spi_byte(spi_seen + 2 * k + 1), spi_byte(spi_seen + 2 * k)});
            end
        end

        if (from_ram)
        begin
            check("dram_rd_count", i_devices.dram_rd_q.size(), words);
            for (k = 0; k < words; k++)
            begin
                check("dram_rd_addr", i_devices.dram_rd_q[k], src_seq[k]);
            end
        end
        if (to_ram)
        begin
            check("dram_wr_count", i_devices.dram_wr_q.size(), words);
            for (k = 0; k < words; k++)
            begin
                check("dram_addr_wrdata", i_devices.dram_wr_q[k], {dst_seq[k], exp_w[k]});
            end
        end
        if (dev == DEV_IDE)
        begin
            check("ide_count", i_devices.ide_q.size(), words);
            for (k = 0; k < words; k++)
            begin
                if (wnr)
                begin
                    check("ide_rnw_out", i_devices.ide_q[k], {1'b0, exp_w[k]});
                end
                else
                begin
                    check("ide_rnw", i_devices.ide_q[k][16], 1);
                end
            end
            ide_seen += words;
        end
        if (dev == DEV_SPI)
        begin
            check("spi_count", i_devices.spi_q.size(), 2 * words);
            for (k = 0; k < words; k++)
            begin
                check("spi_wrdata", i_devices.spi_q[2 * k], wnr ? exp_w[k][7:0] : 8'hff);
                check("spi_wrdata", i_devices.spi_q[2 * k + 1], wnr ? exp_w[k][15:8] : 8'hff);
            end
            spi_seen += 2 * words;
        end
        if ((dev == DEV_CRAM) || (dev == DEV_SFILE))
        begin
            check("table_we_count", i_devices.tbl_q.size(), words);
            for (k = 0; k < words; k++)
            begin
                check("table_wraddr_data", i_devices.tbl_q[k],
                      {dev == DEV_SFILE, dst_seq[k][7:0], exp_w[k]});
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'h6e1c_10d3));
        rst_n   = 1'b0;
        port_wr = '0;
        zdata   = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check("idle_outputs", {dma_act, dram_req, spi_req, ide_req, cram_we, sfile_we}, 0);
        rst_n = 1'b1;

        run(DEV_RAM, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        repeat (3) run(DEV_RAM, 1'($urandom), 1'b0, 1'b0, 1'b0, 1'b0);
        run(DEV_RAM, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);   // both sides on 128-word lines
        run(DEV_RAM, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
        run(DEV_RAM, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        run(DEV_RAM, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        run(DEV_IDE, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        run(DEV_IDE, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        run(DEV_SPI, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        run(DEV_SPI, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        run(DEV_CRAM, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        run(DEV_SFILE, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: all.f
hw/dma_pkg.sv
hw/dma_cfg_if.sv
hw/dma_regs.sv
hw/dma_addr_gen.sv
hw/dma_engine.sv
hw/dma_top.sv
tests/tb_dma_devices.sv
tests/tb_dma.sv

// File: Bender.yml
package:
  name: dma_engine

sources:
  - files:
      - hw/dma_pkg.sv
      - hw/dma_cfg_if.sv
      - hw/dma_regs.sv
      - hw/dma_addr_gen.sv
      - hw/dma_engine.sv
      - hw/dma_top.sv
  - target: test
    files:
      - tests/tb_dma_devices.sv
      - tests/tb_dma.sv
